// ==== common/txFifoPkg.sv ====
// Shared widths, entry layout and delimiter codes for the transmit byte FIFO; import with txFifoPkg::*
`default_nettype none

package txFifoPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word and byte geometry
  ////////////////////////////////////////////////////////////////////////////

  // Payload bits carried by one written word
  parameter int TX_DATA_WIDTH  = 32;
  // Bits per emitted byte
  parameter int TX_BYTE_WIDTH  = 8;
  // Byte lanes per word, also the byte-enable mask width
  parameter int TX_LANES       = TX_DATA_WIDTH / TX_BYTE_WIDTH;
  // Frame delimiter tag width
  parameter int TX_DELIM_WIDTH = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Stored entry layout
  ////////////////////////////////////////////////////////////////////////////

  // Entry is {delimiter, byte-enable mask, payload}, payload at bit 0
  parameter int TX_ENTRY_MASK_LSB  = TX_DATA_WIDTH;
  parameter int TX_ENTRY_DELIM_LSB = TX_ENTRY_MASK_LSB + TX_LANES;
  // Full entry width, 38 bits with the default geometry
  parameter int TX_ENTRY_WIDTH     = TX_ENTRY_DELIM_LSB + TX_DELIM_WIDTH;

  ////////////////////////////////////////////////////////////////////////////
  // Frame delimiter codes
  ////////////////////////////////////////////////////////////////////////////

  // Opens a frame
  parameter logic [TX_DELIM_WIDTH-1:0] TX_DELIM_FIRST  = 2'b00;
  // Inside a frame
  parameter logic [TX_DELIM_WIDTH-1:0] TX_DELIM_MIDDLE = 2'b01;
  // Closes a frame
  parameter logic [TX_DELIM_WIDTH-1:0] TX_DELIM_LAST   = 2'b10;
  // Frame held in one word, passed through untouched
  parameter logic [TX_DELIM_WIDTH-1:0] TX_DELIM_SINGLE = 2'b11;

endpackage

`default_nettype wire

// ==== txFifoBuffer/txFifoWordBuffer.sv ====
// Word storage of the transmit FIFO; holds entries, tracks level and flags, serves registered pops
`timescale 1ns/100ps
`default_nettype none

module txFifoWordBuffer
  import txFifoPkg::*;
#(
  parameter int ADDR_WIDTH             = 4,
  parameter int ALMOST_FULL_THRESHOLD  = 12,
  parameter int ALMOST_EMPTY_THRESHOLD = 2
)
(
  input  wire                       macCoreTxClk,
  input  wire                       macCoreClkHardRst_n,
  // Clears pointers and level at the next edge
  input  wire                       flush,
  // Write port
  input  wire                       wrStrobe,
  input  wire [TX_ENTRY_WIDTH-1:0]  wrEntry,
  // Pop port towards the unpacker
  input  wire                       popStrobe,
  output logic                      wordAvail,
  output logic [TX_ENTRY_WIDTH-1:0] popEntry,
  output logic                      popValid,
  // Level flags
  output logic                      full,
  output logic                      almostFull,
  output logic                      almostEmpty
);

  ////////////////////////////////////////////////////////////////////////////
  // Local constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int DEPTH = 1 << ADDR_WIDTH;
  // Thresholds sized to the level counter
  localparam logic [ADDR_WIDTH:0] AF_LEVEL = (ADDR_WIDTH+1)'(ALMOST_FULL_THRESHOLD);
  localparam logic [ADDR_WIDTH:0] AE_LEVEL = (ADDR_WIDTH+1)'(ALMOST_EMPTY_THRESHOLD);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and control state
  ////////////////////////////////////////////////////////////////////////////

  logic [TX_ENTRY_WIDTH-1:0] fifoMem [DEPTH];
  logic [ADDR_WIDTH-1:0]     wrPtr;
  logic [ADDR_WIDTH-1:0]     rdPtr;
  // Words held, 0 to DEPTH, one extra bit for full
  logic [ADDR_WIDTH:0]       level;

  // Pointers, level and pop pulse
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      level    <= '0;
      popValid <= 1'b0;
    end
    else if (flush)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      level    <= '0;
      popValid <= 1'b0;
    end
    else
    begin
      if (wrStrobe)
        wrPtr <= wrPtr + 1'b1;
      if (popStrobe)
        rdPtr <= rdPtr + 1'b1;
      // Entry is on popEntry one cycle after the pop
      popValid <= popStrobe;
      // Simultaneous write and pop leave the level unchanged
      case ({wrStrobe, popStrobe})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // Memory write and registered read
  always_ff @(posedge macCoreTxClk)
  begin
    if (wrStrobe)
      fifoMem[wrPtr] <= wrEntry;
    if (popStrobe)
      popEntry <= fifoMem[rdPtr];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status from the level
  ////////////////////////////////////////////////////////////////////////////

  assign wordAvail   = (level != '0);
  // MSB is set only at level == DEPTH
  assign full        = level[ADDR_WIDTH];
  assign almostFull  = (level >= AF_LEVEL);
  assign almostEmpty = (level <= AE_LEVEL);

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // Producer honours full
  noWriteWhenFull: assert property (
    @(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    wrStrobe |-> !full
  );

  // Unpacker pops only a held word
  noPopWhenEmpty: assert property (
    @(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    popStrobe |-> wordAvail
  );

  // Threshold setting keeps flags ordered
  fullImpliesAlmostFull: assert property (
    @(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    full |-> almostFull
  );

  // A word with no enabled lane would stall the unpacker
  noZeroMaskWrite: assert property (
    @(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    wrStrobe |-> (wrEntry[TX_ENTRY_MASK_LSB +: TX_LANES] != '0)
  );

endmodule

`default_nettype wire

// ==== txFifoUnpack/txFifoByteUnpacker.sv ====
// Byte unpacker of the transmit FIFO; stages one word, emits enabled lanes with rewritten delimiters
`timescale 1ns/100ps
`default_nettype none

module txFifoByteUnpacker
  import txFifoPkg::*;
(
  input  wire                       macCoreTxClk,
  input  wire                       macCoreClkHardRst_n,
  input  wire                       flush,
  // Word buffer side
  input  wire [TX_ENTRY_WIDTH-1:0]  popEntry,
  input  wire                       popValid,
  input  wire                       wordAvail,
  output logic                      popStrobe,
  // Transmit controller side
  input  wire                       txByteRead,
  output logic                      txByteReady,
  output logic                      txByteValid,
  output logic [TX_BYTE_WIDTH-1:0]  txByteData,
  output logic [TX_DELIM_WIDTH-1:0] txByteDelim
);

  ////////////////////////////////////////////////////////////////////////////
  // Staging word
  ////////////////////////////////////////////////////////////////////////////

  logic [TX_DATA_WIDTH-1:0]  stageData;
  logic [TX_DELIM_WIDTH-1:0] stageDelim;
  // Lanes not yet emitted
  logic [TX_LANES-1:0]       remMask;
  // At least one byte of this word already read
  logic                      byteEmitted;

  // Lane decode of the current read
  logic [TX_LANES-1:0]       laneSel;
  logic [TX_LANES-1:0]       remAfterRead;
  logic                      lastLane;
  logic                      stageEmpty;
  logic                      lastRead;
  logic [TX_BYTE_WIDTH-1:0]  laneByte;
  logic [TX_DELIM_WIDTH-1:0] laneDelim;

  ////////////////////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////////////////////

  // Lowest remaining lane as one-hot
  assign laneSel      = remMask & (~remMask + 1'b1);
  assign remAfterRead = remMask & ~laneSel;
  // Selected lane is the final one of the word
  assign lastLane     = (remAfterRead == '0);
  assign stageEmpty   = (remMask == '0);
  assign txByteReady  = !stageEmpty;

  // Byte mux on the one-hot lane
  always_comb
  begin
    laneByte = '0;
    for (int i = 0; i < TX_LANES; i++)
    begin
      if (laneSel[i])
        laneByte = stageData[i*TX_BYTE_WIDTH +: TX_BYTE_WIDTH];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Delimiter rewrite
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (stageDelim)
      // First only on the word's first emitted byte
      TX_DELIM_FIRST:
        laneDelim = byteEmitted ? TX_DELIM_MIDDLE : TX_DELIM_FIRST;
      // Last only on the word's final lane
      TX_DELIM_LAST:
        laneDelim = lastLane ? TX_DELIM_LAST : TX_DELIM_MIDDLE;
      TX_DELIM_SINGLE:
        laneDelim = TX_DELIM_SINGLE;
      default:
        laneDelim = TX_DELIM_MIDDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Prefetch request
  ////////////////////////////////////////////////////////////////////////////

  // Read that drains the stage
  assign lastRead  = txByteRead && lastLane;
  // Empty stage with no word returning, or stage draining now
  // popValid marks the cycle where a popped word is still on its way
  assign popStrobe = wordAvail && !flush &&
                     ((stageEmpty && !popValid) || lastRead);

  ////////////////////////////////////////////////////////////////////////////
  // Stage control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      remMask     <= '0;
      byteEmitted <= 1'b0;
    end
    else if (flush)
    begin
      remMask     <= '0;
      byteEmitted <= 1'b0;
    end
    else if (popValid)
    begin
      // New word arrives only into an empty stage
      remMask     <= popEntry[TX_ENTRY_MASK_LSB +: TX_LANES];
      byteEmitted <= 1'b0;
    end
    else if (txByteRead)
    begin
      remMask     <= remAfterRead;
      byteEmitted <= 1'b1;
    end
  end

  // Stage payload and tag
  always_ff @(posedge macCoreTxClk)
  begin
    if (popValid)
    begin
      stageData  <= popEntry[0 +: TX_DATA_WIDTH];
      stageDelim <= popEntry[TX_ENTRY_DELIM_LSB +: TX_DELIM_WIDTH];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte output stage
  ////////////////////////////////////////////////////////////////////////////

  // Valid one cycle after each read, dropped by flush
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      txByteValid <= 1'b0;
    else if (flush)
      txByteValid <= 1'b0;
    else
      txByteValid <= txByteRead;
  end

  always_ff @(posedge macCoreTxClk)
  begin
    if (txByteRead)
    begin
      txByteData  <= laneByte;
      txByteDelim <= laneDelim;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // Consumer reads only while a byte is staged
  noReadWhenNotReady: assert property (
    @(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    txByteRead |-> txByteReady
  );

  // Returned word never overwrites undrained lanes
  popIntoEmptyStage: assert property (
    @(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    popValid |-> stageEmpty
  );

endmodule

`default_nettype wire

// ==== verilog/txFifoTop.sv ====
// Transmit byte FIFO top: word writes in, enabled bytes out with rewritten delimiters
`timescale 1ns/100ps
`default_nettype none

module txFifoTop
  import txFifoPkg::*;
#(
  // Word buffer depth is 2**ADDR_WIDTH
  parameter int ADDR_WIDTH             = 4,
  // Level at or above which almost-full is raised
  parameter int ALMOST_FULL_THRESHOLD  = 12,
  // Level at or below which almost-empty is raised
  parameter int ALMOST_EMPTY_THRESHOLD = 2
)
(
  // Clock and reset
  input  wire                       macCoreTxClk,
  input  wire                       macCoreClkHardRst_n,
  // Synchronous clear of buffer and unpacker
  input  wire                       txFifoFlush,
  // Write side, one word per strobe
  input  wire                       txFifoWrite,
  input  wire [TX_DATA_WIDTH-1:0]   txFifoWrData,
  input  wire [TX_LANES-1:0]        txFifoWrEn,
  input  wire [TX_DELIM_WIDTH-1:0]  txFifoWrDelim,
  output logic                      txFifoFull,
  output logic                      txFifoAlmostFull,
  output logic                      txFifoAlmostEmpty,
  // Read side, one byte per strobe
  input  wire                       txByteRead,
  output logic                      txByteReady,
  output logic                      txByteValid,
  output logic [TX_BYTE_WIDTH-1:0]  txByteData,
  output logic [TX_DELIM_WIDTH-1:0] txByteDelim
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  // Packed write entry
  logic [TX_ENTRY_WIDTH-1:0] wrEntry;
  // Buffer to unpacker handshake
  logic [TX_ENTRY_WIDTH-1:0] popEntry;
  logic                      popStrobe;
  logic                      popValid;
  logic                      wordAvail;

  // Pack payload, mask and delimiter into one stored entry
  assign wrEntry[0 +: TX_DATA_WIDTH]                 = txFifoWrData;
  assign wrEntry[TX_ENTRY_MASK_LSB +: TX_LANES]      = txFifoWrEn;
  assign wrEntry[TX_ENTRY_DELIM_LSB +: TX_DELIM_WIDTH] = txFifoWrDelim;

  // Word storage, level and flags
  txFifoWordBuffer #(
    .ADDR_WIDTH             (ADDR_WIDTH),
    .ALMOST_FULL_THRESHOLD  (ALMOST_FULL_THRESHOLD),
    .ALMOST_EMPTY_THRESHOLD (ALMOST_EMPTY_THRESHOLD)
  ) u_wordBuffer (
    .macCoreTxClk        (macCoreTxClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .flush               (txFifoFlush),
    .wrStrobe            (txFifoWrite),
    .wrEntry             (wrEntry),
    .popStrobe           (popStrobe),
    .wordAvail           (wordAvail),
    .popEntry            (popEntry),
    .popValid            (popValid),
    .full                (txFifoFull),
    .almostFull          (txFifoAlmostFull),
    .almostEmpty         (txFifoAlmostEmpty)
  );

  // Word to byte conversion and delimiter rewrite
  txFifoByteUnpacker u_byteUnpacker (
    .macCoreTxClk        (macCoreTxClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .flush               (txFifoFlush),
    .popEntry            (popEntry),
    .popValid            (popValid),
    .wordAvail           (wordAvail),
    .txByteRead          (txByteRead),
    .popStrobe           (popStrobe),
    .txByteReady         (txByteReady),
    .txByteValid         (txByteValid),
    .txByteData          (txByteData),
    .txByteDelim         (txByteDelim)
  );

endmodule

`default_nettype wire

// ==== dv/txFifoTbTasks.svh ====
// Driver, wait, check and directed test tasks included by the transmit FIFO testbench module
`ifndef TX_FIFO_TB_TASKS_SVH
`define TX_FIFO_TB_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Check and wait helpers
////////////////////////////////////////////////////////////////////////////

task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
  if (actual !== expected)
  begin
    $display("FAIL at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    $display("TEST FAILED");
    $fatal(1, "Stopped at first mismatch");
  end
endtask

task automatic waitCycles(input int count);
  for (int i = 0; i < count; i++)
  begin
    @(posedge macCoreTxClk);
    #DRIVE_DELAY;
  end
endtask

// Polls byte-ready once per cycle up to a bounded count
task automatic waitReady();
  int cycles;
  cycles = 0;
  while (!txByteReady)
  begin
    if (cycles >= READY_TIMEOUT)
    begin
      $display("Timed out waiting for the FIFO to offer a byte");
      $display("TEST FAILED");
      $fatal(1, "Byte ready never rose");
    end
    @(posedge macCoreTxClk);
    #DRIVE_DELAY;
    cycles++;
  end
endtask

// Flags predicted from the held word count
task automatic checkFlags(input int level);
  checkValue(32'(txFifoFull), (level == DEPTH) ? 32'd1 : 32'd0, "full flag");
  checkValue(32'(txFifoAlmostFull), (level >= ALMOST_FULL_THRESHOLD) ? 32'd1 : 32'd0,
             "almost-full flag");
  checkValue(32'(txFifoAlmostEmpty), (level <= ALMOST_EMPTY_THRESHOLD) ? 32'd1 : 32'd0,
             "almost-empty flag");
endtask

////////////////////////////////////////////////////////////////////////////
// Drivers
////////////////////////////////////////////////////////////////////////////

task automatic randomMask(output logic [TX_LANES-1:0] mask);
  logic [31:0] r;
  // Zero masks are illegal so draw again
  do
  begin
    r = $random(seed);
  end
  while (r[TX_LANES-1:0] == '0);
  mask = r[TX_LANES-1:0];
endtask

task automatic writeWord(input logic [TX_DATA_WIDTH-1:0] data,
                         input logic [TX_LANES-1:0] mask,
                         input logic [TX_DELIM_WIDTH-1:0] delim);
  @(posedge macCoreTxClk);
  #DRIVE_DELAY;
  txFifoWrite   = 1'b1;
  txFifoWrData  = data;
  txFifoWrEn    = mask;
  txFifoWrDelim = delim;
  @(posedge macCoreTxClk);
  #DRIVE_DELAY;
  txFifoWrite = 1'b0;
  queueExpected(data, mask, delim);
endtask

task automatic flushFifo();
  @(posedge macCoreTxClk);
  #DRIVE_DELAY;
  txFifoFlush = 1'b1;
  @(posedge macCoreTxClk);
  #DRIVE_DELAY;
  txFifoFlush = 1'b0;
  expData.delete();
  expDelim.delete();
endtask

// One read strobe with the byte checked in the cycle after it
task automatic readByte();
  logic [TX_BYTE_WIDTH-1:0]  data;
  logic [TX_DELIM_WIDTH-1:0] delim;
  if (expData.size() == 0)
  begin
    $display("Tried to read a byte the reference model does not expect");
    $display("TEST FAILED");
    $fatal(1, "Reference queue empty");
  end
  waitReady();
  txByteRead = 1'b1;
  @(posedge macCoreTxClk);
  #DRIVE_DELAY;
  txByteRead = 1'b0;
  data  = expData.pop_front();
  delim = expDelim.pop_front();
  checkValue(32'(txByteValid), 1, "byte valid after read");
  checkValue(32'(txByteData), 32'(data), "byte data");
  checkValue(32'(txByteDelim), 32'(delim), "byte delimiter");
endtask

// Reads every expected byte and then expects no further byte
task automatic drainExpected();
  while (expData.size() != 0)
    readByte();
  waitCycles(4);
  checkValue(32'(txByteReady), 0, "no extra byte after drain");
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic testResetState();
  waitCycles(1);
  checkFlags(0);
  checkValue(32'(txByteReady), 0, "byte ready after reset");
endtask

task automatic testSingleWord();
  writeWord(32'hA3B2C1D0, 4'hF, TX_DELIM_SINGLE);
  drainExpected();
endtask

task automatic testRandomMasks();
  logic [TX_LANES-1:0] mask;
  for (int w = 0; w < 6; w++)
  begin
    randomMask(mask);
    writeWord($random(seed), mask, TX_DELIM_MIDDLE);
  end
  drainExpected();
endtask

// First word, two middle words, last word
task automatic testFrame();
  logic [TX_LANES-1:0] mask;
  randomMask(mask);
  writeWord($random(seed), mask, TX_DELIM_FIRST);
  for (int w = 0; w < 2; w++)
  begin
    randomMask(mask);
    writeWord($random(seed), mask, TX_DELIM_MIDDLE);
  end
  randomMask(mask);
  writeWord($random(seed), mask, TX_DELIM_LAST);
  drainExpected();
endtask

// Stage holds one word so N writes settle at level N - 1
task automatic testLevelFlags();
  flushFifo();
  for (int n = 1; n <= DEPTH + 1; n++)
  begin
    writeWord($random(seed), 4'hF, TX_DELIM_MIDDLE);
    // First word leaves the buffer once it is loaded into the stage
    waitReady();
    checkFlags(n - 1);
  end
endtask

task automatic testFlushMidBurst();
  logic [TX_LANES-1:0] mask;
  readByte();
  readByte();
  waitReady();
  // Read and flush in the same cycle cancel the read
  txByteRead  = 1'b1;
  txFifoFlush = 1'b1;
  @(posedge macCoreTxClk);
  #DRIVE_DELAY;
  txByteRead  = 1'b0;
  txFifoFlush = 1'b0;
  expData.delete();
  expDelim.delete();
  checkValue(32'(txByteValid), 0, "no byte valid after flushed read");
  checkValue(32'(txByteReady), 0, "byte ready after flush");
  checkFlags(0);
  waitCycles(3);
  checkValue(32'(txByteValid), 0, "byte valid stays low after flush");
  randomMask(mask);
  writeWord($random(seed), mask, TX_DELIM_SINGLE);
  drainExpected();
endtask

`endif

// ==== dv/txFifoTb.sv ====
// Testbench top for the transmit byte FIFO; clock, reset, reference byte queue and test sequence
`timescale 1ns/100ps
`default_nettype none

module txFifoTb;
  import txFifoPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Local constants, matching the DUT defaults
  ////////////////////////////////////////////////////////////////////////////

  localparam int DEPTH                  = 16;
  localparam int ALMOST_FULL_THRESHOLD  = 12;
  localparam int ALMOST_EMPTY_THRESHOLD = 2;
  localparam int CLK_HALF               = 10;
  // Inputs change this long after each rising edge
  localparam int DRIVE_DELAY            = 2;
  localparam int READY_TIMEOUT          = 64;

  // DUT inputs
  logic                      macCoreTxClk;
  logic                      macCoreClkHardRst_n;
  logic                      txFifoFlush;
  logic                      txFifoWrite;
  logic [TX_DATA_WIDTH-1:0]  txFifoWrData;
  logic [TX_LANES-1:0]       txFifoWrEn;
  logic [TX_DELIM_WIDTH-1:0] txFifoWrDelim;
  logic                      txByteRead;
  // DUT outputs
  wire                       txFifoFull;
  wire                       txFifoAlmostFull;
  wire                       txFifoAlmostEmpty;
  wire                       txByteReady;
  wire                       txByteValid;
  wire [TX_BYTE_WIDTH-1:0]   txByteData;
  wire [TX_DELIM_WIDTH-1:0]  txByteDelim;

  // Stimulus seed
  integer seed = 86;

  // Expected bytes and delimiters in emit order
  logic [TX_BYTE_WIDTH-1:0]  expData [$];
  logic [TX_DELIM_WIDTH-1:0] expDelim [$];

  txFifoTop u_dut (
    .macCoreTxClk        (macCoreTxClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .txFifoFlush         (txFifoFlush),
    .txFifoWrite         (txFifoWrite),
    .txFifoWrData        (txFifoWrData),
    .txFifoWrEn          (txFifoWrEn),
    .txFifoWrDelim       (txFifoWrDelim),
    .txFifoFull          (txFifoFull),
    .txFifoAlmostFull    (txFifoAlmostFull),
    .txFifoAlmostEmpty   (txFifoAlmostEmpty),
    .txByteRead          (txByteRead),
    .txByteReady         (txByteReady),
    .txByteValid         (txByteValid),
    .txByteData          (txByteData),
    .txByteDelim         (txByteDelim)
  );

  // Reference model, one entry per enabled lane, lowest lane first
  task automatic queueExpected(input logic [TX_DATA_WIDTH-1:0] data,
                               input logic [TX_LANES-1:0] mask,
                               input logic [TX_DELIM_WIDTH-1:0] delim);
    int                        remaining;
    int                        emitted;
    logic [TX_DELIM_WIDTH-1:0] laneDelim;
    remaining = 0;
    emitted   = 0;
    for (int i = 0; i < TX_LANES; i++)
    begin
      if (mask[i])
        remaining++;
    end
    for (int i = 0; i < TX_LANES; i++)
    begin
      if (mask[i])
      begin
        // First kept on the first byte, last kept on the final lane
        if (delim == TX_DELIM_FIRST)
          laneDelim = (emitted == 0) ? TX_DELIM_FIRST : TX_DELIM_MIDDLE;
        else if (delim == TX_DELIM_LAST)
          laneDelim = (remaining == 1) ? TX_DELIM_LAST : TX_DELIM_MIDDLE;
        else
          laneDelim = delim;
        expData.push_back(data[i*TX_BYTE_WIDTH +: TX_BYTE_WIDTH]);
        expDelim.push_back(laneDelim);
        emitted++;
        remaining--;
      end
    end
  endtask

  `include "txFifoTbTasks.svh"

  // Free running clock
  initial
  begin
    macCoreTxClk = 1'b0;
    forever #CLK_HALF macCoreTxClk = ~macCoreTxClk;
  end

  // Reset, then the directed tests in order
  initial
  begin
    macCoreClkHardRst_n = 1'b0;
    txFifoFlush         = 1'b0;
    txFifoWrite         = 1'b0;
    txFifoWrData        = '0;
    txFifoWrEn          = '0;
    txFifoWrDelim       = TX_DELIM_MIDDLE;
    txByteRead          = 1'b0;
    repeat (10) @(posedge macCoreTxClk);
    #DRIVE_DELAY;
    macCoreClkHardRst_n = 1'b1;
    testResetState();
    testSingleWord();
    testRandomMasks();
    testFrame();
    testLevelFlags();
    testFlushMidBurst();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+dv
common/txFifoPkg.sv
txFifoBuffer/txFifoWordBuffer.sv
txFifoUnpack/txFifoByteUnpacker.sv
verilog/txFifoTop.sv
dv/txFifoTb.sv

// ==== run.sh ====
#!/bin/sh
# Compiles the transmit FIFO testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module txFifoTb -f build.f -o txFifoSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit $status
fi

./obj_dir/txFifoSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

echo "Simulation exited cleanly"
exit 0
